// ==== list.f ====
+incdir+.
ringMsgPkg.sv
ringAddrPkg.sv
ringSource.sv
ringMemNode.sv
ringSink.sv
ringTop.sv
ringProps.sv
ringTb.sv

// ==== ringAddrPkg.sv ====
// ====================
// bank and control target share the same bits of the address word
// ====================
`include "ringSettings.svh"

package ringAddrPkg;

	localparam int MemPadW  = `ADDR_W - 2 - `NODE_W - `TILE_IX_W; // low bits ignored
	localparam int CmdW     = 4;
	localparam int CtrlPadW = `ADDR_W - 2 - `NODE_W - CmdW;

	typedef enum logic [1:0]
	{
		RAM  = 2'd0, // tiles in a bank
		ZERO = 2'd1, // reads zero, stores dropped
		BAD0 = 2'd2, // never claimed
		BAD1 = 2'd3
	} ringRegionT;

	// only PING is known, any other code falls through to the sink
	typedef enum logic [CmdW-1:0]
	{
		PING = 4'h1
	} ringCmdT;

	typedef struct packed
	{
		ringRegionT region;
		logic [`NODE_W-1:0] bank;
		logic [`TILE_IX_W-1:0] tile;
		logic [MemPadW-1:0] pad;
	} ringMemAddrT;

	typedef struct packed
	{
		logic [1:0] region; // don't care on control
		logic [`NODE_W-1:0] target;
		ringCmdT cmd;
		logic [CtrlPadW-1:0] pad;
	} ringCtrlAddrT;

	// memory view for LOAD/STORE, control view for CTRL
	typedef union packed
	{
		ringMemAddrT mem;
		ringCtrlAddrT ctrl;
	} ringAddrU;

endpackage

// ==== ringMemNode.sv ====
// ====================
// fixed 2 cycle latency for every message, claimed or not
// store lands at stage 1, so a following load sees it
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringMemNode
#(
	parameter int nodeIx = 0 // position in the chain
)
(
	input logic clock,
	input logic arstN,

	// ring link i
	input logic inValid,
	input ringMsgPkg::ringOpT inOp,
	input logic [`SEQ_W-1:0] inSeq,
	input ringAddrPkg::ringAddrU inAddr,
	input logic [`TILE_W-1:0] inData,

	// ring link i+1
	output logic outValid,
	output ringMsgPkg::ringOpT outOp,
	output logic [`SEQ_W-1:0] outSeq,
	output ringAddrPkg::ringAddrU outAddr,
	output logic [`TILE_W-1:0] outData
);
	import ringMsgPkg::*;
	import ringAddrPkg::*;

	localparam int CntW = 16; // store counter width
	localparam int Tiles = 1 << `TILE_IX_W;
	localparam logic [`NODE_W-1:0] MyIx = `NODE_W'(nodeIx);

	// tile bank, no reset on contents
	logic [`TILE_W-1:0] bankMem [0:Tiles-1];

	// claim decode on the incoming slot
	logic isCtrl;
	logic memHit; // RAM or ZERO region of this bank
	logic pingHit; // PING aimed at this node
	logic claim;
	logic doStore; // RAM store, zero-page stores are dropped

	// stage 1 registers
	logic s1Valid;
	logic s1Claim;
	ringOpT s1Op;
	logic [`SEQ_W-1:0] s1Seq;
	ringAddrU s1Addr;
	logic [`TILE_W-1:0] s1Data;
	logic [`TILE_W-1:0] rdData; // bank read at the incoming tile

	logic [CntW-1:0] storeCnt;
	logic [`TILE_W-1:0] pingData;

	// stage 2 next values
	ringOpT nxtOp;
	logic [`TILE_W-1:0] nxtData;

	always_comb
	begin
		isCtrl = (inOp == CTRL);
		// same bits, read as bank or as control target
		memHit = (inAddr.mem.bank == MyIx) &&
			((inAddr.mem.region == RAM) || (inAddr.mem.region == ZERO));
		pingHit = (inAddr.ctrl.target == MyIx) && (inAddr.ctrl.cmd == PING);
		claim = 1'b0;
		if (inValid && !isAnswered(inOp))
		begin
			if (isCtrl)
				claim = pingHit;
			else
				claim = memHit && ((inOp == LOAD) || (inOp == STORE));
		end
		doStore = claim && (inOp == STORE) && (inAddr.mem.region == RAM);
	end

	// control state of both stages
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			s1Valid <= 1'b0;
			s1Claim <= 1'b0;
			storeCnt <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			s1Valid <= inValid;
			s1Claim <= claim;
			if (doStore)
				storeCnt <= storeCnt + 1'b1; // wraps at 16 bits
			outValid <= s1Valid;
		end
	end

	// SRAM port, write and registered read
	always_ff @(posedge clock)
	begin
		rdData <= bankMem[inAddr.mem.tile];
		if (doStore)
			bankMem[inAddr.mem.tile] <= inData;
	end

	// stage 1 payload
	always_ff @(posedge clock)
	begin
		s1Op <= inOp;
		s1Seq <= inSeq;
		s1Addr <= inAddr;
		s1Data <= inData;
	end

	// node index in the low byte, store count above it
	assign pingData = `TILE_W'({storeCnt, 8'(nodeIx)});

	// stage 2, answer or pass unchanged
	always_comb
	begin
		nxtOp = s1Op;
		nxtData = s1Data;
		if (s1Claim)
		begin
			nxtOp = okCode(s1Op);
			case (s1Op)
				LOAD:
					nxtData = (s1Addr.mem.region == ZERO) ? '0 : rdData;
				CTRL:
					nxtData = pingData;
				default:
					nxtData = s1Data; // store echoes its data
			endcase
		end
	end

	// stage 2 payload
	always_ff @(posedge clock)
	begin
		outOp <= nxtOp;
		outSeq <= s1Seq;
		outAddr <= s1Addr;
		outData <= nxtData;
	end

endmodule

// ==== ringMsgPkg.sv ====
// ====================
// opcode top bit marks an answered message
// ====================
package ringMsgPkg;

	// request codes low, response codes with bit 3 set
	typedef enum logic [3:0]
	{
		IDLE     = 4'h0,
		LOAD     = 4'h1,
		STORE    = 4'h2,
		CTRL     = 4'h3,
		OK_LOAD  = 4'h9,
		OK_STORE = 4'hA,
		OK_CTRL  = 4'hB,
		ERR      = 4'hF
	} ringOpT;

	// true once some node has rewritten the message
	function automatic logic isAnswered(ringOpT op);
		return op[3];
	endfunction

	// legal request from outside
	function automatic logic isRequest(ringOpT op);
		return (op == LOAD) || (op == STORE) || (op == CTRL);
	endfunction

	// response code for a claimed request
	function automatic ringOpT okCode(ringOpT op);
		ringOpT res;
		case (op)
			LOAD:    res = OK_LOAD;
			STORE:   res = OK_STORE;
			CTRL:    res = OK_CTRL;
			default: res = ERR; // nothing else is ever claimed
		endcase
		return res;
	endfunction

endpackage

// ==== ringProps.sv ====
// ====================
// watches the response strobe only, sequence history restarts at reset
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringProps
(
	input logic clock,
	input logic arstN,
	input logic rspValid,
	input ringMsgPkg::ringOpT rspOp,
	input logic [`SEQ_W-1:0] rspSeq
);
	import ringMsgPkg::*;

	logic seenRsp; // some response left since reset
	logic [`SEQ_W-1:0] lastSeq;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			seenRsp <= 1'b0;
			lastSeq <= '0;
		end
		else if (rspValid)
		begin
			seenRsp <= 1'b1;
			lastSeq <= rspSeq;
		end
	end

	seqStep: assert property (@(posedge clock) disable iff (!arstN)
		rspValid && seenRsp |-> rspSeq == `SEQ_W'(lastSeq + 1'b1))
		else $error("response sequence did not step by one");

	// only answered codes or ERR leave the sink
	answered: assert property (@(posedge clock) disable iff (!arstN)
		rspValid |-> isAnswered(rspOp))
		else $error("response carries a request opcode");

	quietReset: assert property (@(posedge clock) !arstN |-> !rspValid)
		else $error("response strobe high during reset");

endmodule

// ==== ringSettings.svh ====
// ====================
// ring sizing, RING_NODES must fit in NODE_W bank bits
// ADDR_W must hold region, bank, tile index and the control fields
// ====================
`ifndef RING_SETTINGS_SVH
`define RING_SETTINGS_SVH

// node count in the chain
`define RING_NODES 4

// bits of a bank / target node field in the address word
`define NODE_W 2

// tile payload width
`define TILE_W 128

// tile index bits per bank, 64 tiles
`define TILE_IX_W 6

// response sequence number, wraps freely
`define SEQ_W 12

// ring address word
`define ADDR_W 24

`endif

// ==== ringSink.sv ====
// ====================
// anything still unanswered at the end of the chain becomes ERR
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringSink
(
	input logic clock,
	input logic arstN,

	// last ring link
	input logic msgValid,
	input ringMsgPkg::ringOpT msgOp,
	input logic [`SEQ_W-1:0] msgSeq,
	input ringAddrPkg::ringAddrU msgAddr,
	input logic [`TILE_W-1:0] msgData,

	// response strobe to outside
	output logic rspValid,
	output ringMsgPkg::ringOpT rspOp,
	output logic [`SEQ_W-1:0] rspSeq,
	output logic [`TILE_W-1:0] rspData
);
	import ringMsgPkg::*;

	logic isErr;

	always_comb
	begin
		// no node claimed it: bad region, unknown command or absent target
		isErr = !isAnswered(msgOp);
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			rspValid <= 1'b0;
		else
			rspValid <= msgValid;
	end

	// response payload
	always_ff @(posedge clock)
	begin
		rspOp <= isErr ? ERR : msgOp;
		rspSeq <= msgSeq;
		rspData <= isErr ? '0 : msgData; // errors carry zero data
	end

endmodule

// ==== ringSource.sv ====
// ====================
// no back-pressure, one request per cycle at most
// illegal opcodes are dropped without a sequence step
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringSource
(
	input logic clock,
	input logic arstN,

	// request strobe from outside
	input logic reqValid,
	input ringMsgPkg::ringOpT reqOp,
	input ringAddrPkg::ringAddrU reqAddr,
	input logic [`TILE_W-1:0] reqData,

	// ring link 0
	output logic msgValid,
	output ringMsgPkg::ringOpT msgOp,
	output logic [`SEQ_W-1:0] msgSeq,
	output ringAddrPkg::ringAddrU msgAddr,
	output logic [`TILE_W-1:0] msgData
);
	import ringMsgPkg::*;

	logic accept; // legal request this cycle
	logic [`SEQ_W-1:0] seqCnt; // next number to stamp

	assign accept = reqValid && isRequest(reqOp);

	// control side, valid strobe and sequence counter
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			msgValid <= 1'b0;
			seqCnt <= '0;
		end
		else
		begin
			msgValid <= accept;
			if (accept)
				seqCnt <= seqCnt + 1'b1; // wraps at SEQ_W
		end
	end

	// payload, meaningful only while msgValid
	always_ff @(posedge clock)
	begin
		msgOp <= accept ? reqOp : IDLE; // idle slot otherwise
		msgSeq <= seqCnt;
		msgAddr <= reqAddr;
		msgData <= reqData;
	end

endmodule

// ==== ringTb.sv ====
// ====================
// tiles are filled by stores before any load, default sizes assumed for random fields
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringTb;
	import ringMsgPkg::*;
	import ringAddrPkg::*;

	logic clock;
	logic arstN;
	logic reqValid;
	ringOpT reqOp;
	ringAddrU reqAddr;
	logic [`TILE_W-1:0] reqData;
	logic rspValid;
	ringOpT rspOp;
	logic [`SEQ_W-1:0] rspSeq;
	logic [`TILE_W-1:0] rspData;

	// reference model state
	logic [`TILE_W-1:0] tileMem [0:`RING_NODES-1][0:(1 << `TILE_IX_W)-1];
	logic [15:0] storeCnt [0:`RING_NODES-1];
	logic [`SEQ_W-1:0] nextSeq;
	ringOpT expOp [$]; // expected responses, oldest first
	logic [`SEQ_W-1:0] expSeq [$];
	logic [`TILE_W-1:0] expData [$];
	ringOpT eOp;
	logic [`SEQ_W-1:0] eSeq;
	logic [`TILE_W-1:0] eData;

	logic [31:0] rngState;
	string curTest;
	int testErrs;
	int errCount;
	int checkCount;
	int testCount;
	int failedTests;
	int latency;
	logic timedOut;

	ringTop u_dut
	(
		.clock(clock), .arstN(arstN),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqData(reqData),
		.rspValid(rspValid), .rspOp(rspOp), .rspSeq(rspSeq), .rspData(rspData)
	);

	bind ringTop ringProps uProps
	(
		.clock(clock), .arstN(arstN), .rspValid(rspValid), .rspOp(rspOp), .rspSeq(rspSeq)
	);

	always #4 clock = ~clock; // 8 ns period

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic logic [`TILE_W-1:0] randData();
		return `TILE_W'({nextRand(), nextRand(), nextRand(), nextRand()});
	endfunction

	// pattern tied to bank and tile together
	function automatic logic [`TILE_W-1:0] fillData(int bank, int tile);
		return `TILE_W'({4{16'(bank) ^ 16'h5a3c, 16'(tile) ^ 16'h96e1}});
	endfunction

	function automatic ringAddrU memAddr(ringRegionT region, int bank, int tile);
		ringAddrU a;
		a = `ADDR_W'(nextRand()); // random pad bits
		a.mem.region = region;
		a.mem.bank = `NODE_W'(bank);
		a.mem.tile = `TILE_IX_W'(tile);
		return a;
	endfunction

	function automatic ringAddrU ctrlAddr(int target, ringCmdT cmd);
		ringAddrU a;
		a = `ADDR_W'(nextRand()); // region is ignored on control
		a.ctrl.target = `NODE_W'(target);
		a.ctrl.cmd = cmd;
		return a;
	endfunction

	// expected response of one request, in issue order
	function automatic void modelReq(ringOpT op, ringAddrU addr, logic [`TILE_W-1:0] data);
		int bank;
		int tile;
		ringOpT rOp;
		logic [`TILE_W-1:0] rData;
		if (op != LOAD && op != STORE && op != CTRL)
			return; // dropped at the source, no sequence step
		bank = int'(addr.mem.bank); // same bits as the control target
		tile = int'(addr.mem.tile);
		rOp = ERR;
		rData = '0;
		if (op == CTRL)
		begin
			if (addr.ctrl.cmd == PING)
			begin
				rOp = OK_CTRL;
				rData = `TILE_W'({storeCnt[bank], 8'(bank)});
			end
		end
		else if (addr.mem.region == RAM || addr.mem.region == ZERO)
		begin
			rOp = (op == LOAD) ? OK_LOAD : OK_STORE;
			rData = data; // store echo
			if (op == LOAD)
				rData = (addr.mem.region == ZERO) ? '0 : tileMem[bank][tile];
			else if (addr.mem.region == RAM)
			begin
				tileMem[bank][tile] = data;
				storeCnt[bank] = storeCnt[bank] + 1'b1;
			end
		end
		expOp.push_back(rOp);
		expSeq.push_back(nextSeq);
		expData.push_back(rData);
		nextSeq = nextSeq + 1'b1;
	endfunction

	// one cycle per call, so calls in a row go back to back
	task automatic sendReq(ringOpT op, ringAddrU addr, logic [`TILE_W-1:0] data);
		reqValid = 1'b1;
		reqOp = op;
		reqAddr = addr;
		reqData = data;
		modelReq(op, addr, data);
		@(posedge clock);
		#1;
		reqValid = 1'b0;
	endtask

	task automatic randomReq();
		logic [31:0] r;
		ringOpT op;
		ringRegionT region;
		r = nextRand();
		case (r[2:0])
			3'd3, 3'd4: op = STORE;
			3'd5: op = CTRL;
			3'd6: op = ringOpT'(r[11:8] | 4'h4); // never a request code
			default: op = LOAD;
		endcase
		region = (r[15:12] < 4'd11) ? RAM : ringRegionT'(2'(r[15:12] - 4'd10));
		if (op == CTRL)
			sendReq(op, ctrlAddr(int'(r[31:24]),
				(r[20:18] == 3'd0) ? ringCmdT'(4'h0) : PING), randData());
		else
			sendReq(op, memAddr(region, int'(r[31:24]), int'(r[23:16])), randData());
	endtask

	task automatic reportMismatch(string what, logic [`TILE_W-1:0] expVal,
		logic [`TILE_W-1:0] actVal);
		$display("Fail %s %s: expected %0h actual %0h", curTest, what, expVal, actVal);
		testErrs++;
	endtask

	task automatic startTest(string name);
		curTest = name;
		testErrs = 0;
		testCount++;
	endtask

	task automatic endTest();
		int waited;
		waited = 0;
		while (expOp.size() != 0 && waited < 100)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		assert (expOp.size() == 0)
		else
		begin
			$display("Error in %s: responses still missing after %0d cycles", curTest, waited);
			testErrs++;
			timedOut = 1'b1;
			expOp.delete();
			expSeq.delete();
			expData.delete();
		end
		repeat (12) @(posedge clock); // quiet gap, stray responses show up here
		#1;
		errCount += testErrs;
		if (testErrs != 0)
			failedTests++;
		$display("test %s: %0d errors", curTest, testErrs);
	endtask

	// response checker, sampled mid-cycle
	always @(negedge clock)
	begin
		if (arstN && rspValid)
		begin
			assert (expOp.size() != 0)
			else
			begin
				$display("Error in %s: response seq %0d arrived with none expected", curTest, rspSeq);
				testErrs++;
			end
			if (expOp.size() != 0)
			begin
				eOp = expOp.pop_front();
				eSeq = expSeq.pop_front();
				eData = expData.pop_front();
				checkCount++;
				assert (rspOp == eOp) else reportMismatch("op", 128'(eOp), 128'(rspOp));
				assert (rspSeq == eSeq) else reportMismatch("seq", 128'(eSeq), 128'(rspSeq));
				assert (rspData == eData) else reportMismatch("data", eData, rspData);
			end
		end
	end

	initial
	begin
		int bank;
		int tile;
		clock = 1'b0;
		arstN = 1'b1;
		reqValid = 1'b0;
		reqOp = IDLE;
		reqAddr = '0;
		reqData = '0;
		rngState = 32'h4f5127ee;
		nextSeq = '0;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		timedOut = 1'b0;
		for (int b = 0; b < `RING_NODES; b++)
			storeCnt[b] = '0;
		#1;
		arstN = 1'b0;
		startTest("reset");
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clock);
			#1;
			assert (rspValid == 1'b0) else reportMismatch("rspValid", 128'(0), 128'(rspValid));
		end
		arstN = 1'b1;
		endTest();

		startTest("init"); // every tile gets a known value
		for (int b = 0; b < `RING_NODES; b++)
			for (int t = 0; t < (1 << `TILE_IX_W); t++)
				sendReq(STORE, memAddr(RAM, b, t), fillData(b, t));
		endTest();

		startTest("latency");
		sendReq(LOAD, memAddr(RAM, 2, 5), '0);
		latency = 1;
		while (!rspValid && latency < 40)
		begin
			@(posedge clock);
			#1;
			latency++;
		end
		assert (latency == 2 + 2 * `RING_NODES)
		else reportMismatch("cycles", 128'(2 + 2 * `RING_NODES), 128'(latency));
		endTest();

		startTest("storeLoad");
		for (int n = 0; n < 24; n++)
		begin
			bank = int'(nextRand() % `RING_NODES);
			tile = int'(nextRand() % (1 << `TILE_IX_W));
			sendReq(STORE, memAddr(RAM, bank, tile), randData());
			for (int b = 0; b < `RING_NODES; b++)
				sendReq(LOAD, memAddr(RAM, b, tile), randData()); // next cycle on
		end
		endTest();

		startTest("zeroPage");
		for (int n = 0; n < 16; n++)
		begin
			bank = int'(nextRand() % `RING_NODES);
			tile = int'(nextRand() % (1 << `TILE_IX_W));
			sendReq(STORE, memAddr(ZERO, bank, tile), randData());
			sendReq(LOAD, memAddr(ZERO, bank, tile), randData());
			sendReq(LOAD, memAddr(RAM, bank, tile), randData()); // ram tile untouched
		end
		endTest();

		startTest("ping");
		for (int b = 0; b < `RING_NODES; b++)
			sendReq(CTRL, ctrlAddr(b, PING), '0);
		sendReq(STORE, memAddr(RAM, 1, 3), randData());
		for (int b = 0; b < `RING_NODES; b++)
			sendReq(CTRL, ctrlAddr(b, PING), randData());
		endTest();

		startTest("errors");
		for (int n = 0; n < 16; n++)
		begin
			sendReq(LOAD, memAddr(BAD0, n, n * 3), randData());
			sendReq(STORE, memAddr(BAD1, n, n * 5), randData());
			sendReq(CTRL, ctrlAddr(n, ringCmdT'(4'h7)), randData());
			sendReq(IDLE, memAddr(RAM, n, n), randData()); // no response, no seq step
			sendReq(OK_LOAD, memAddr(RAM, n, n), randData());
			sendReq(ringOpT'(4'h6), memAddr(RAM, n, n), randData());
		end
		endTest();

		startTest("random");
		for (int n = 0; n < 2000; n++)
			randomReq();
		endTest();

		$display("%0d tests, %0d failed, %0d responses checked, %0d errors",
			testCount, failedTests, checkCount, errCount);
		if (errCount == 0 && !timedOut)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== ringTop.sv ====
// ====================
// open chain, latency 2 + 2*RING_NODES cycles, responses in order
// ====================
`timescale 1ns/1ns
`include "ringSettings.svh"

module ringTop
(
	input logic clock,
	input logic arstN,
	input logic reqValid,
	input ringMsgPkg::ringOpT reqOp,
	input ringAddrPkg::ringAddrU reqAddr,
	input logic [`TILE_W-1:0] reqData,
	output logic rspValid,
	output ringMsgPkg::ringOpT rspOp,
	output logic [`SEQ_W-1:0] rspSeq,
	output logic [`TILE_W-1:0] rspData
);
	import ringMsgPkg::*;
	import ringAddrPkg::*;

	// link i feeds node i, link RING_NODES feeds the sink
	logic linkValid [0:`RING_NODES];
	ringOpT linkOp [0:`RING_NODES];
	logic [`SEQ_W-1:0] linkSeq [0:`RING_NODES];
	ringAddrU linkAddr [0:`RING_NODES];
	logic [`TILE_W-1:0] linkData [0:`RING_NODES];

	ringSource uSource
	(
		.clock(clock), .arstN(arstN),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqData(reqData),
		.msgValid(linkValid[0]), .msgOp(linkOp[0]), .msgSeq(linkSeq[0]),
		.msgAddr(linkAddr[0]), .msgData(linkData[0])
	);

	for (genvar i = 0; i < `RING_NODES; i++)
	begin : gNode
		ringMemNode #(.nodeIx(i)) uNode
		(
			.clock(clock), .arstN(arstN),
			.inValid(linkValid[i]), .inOp(linkOp[i]), .inSeq(linkSeq[i]),
			.inAddr(linkAddr[i]), .inData(linkData[i]),
			.outValid(linkValid[i+1]), .outOp(linkOp[i+1]), .outSeq(linkSeq[i+1]),
			.outAddr(linkAddr[i+1]), .outData(linkData[i+1])
		);
	end

	ringSink uSink
	(
		.clock(clock), .arstN(arstN),
		.msgValid(linkValid[`RING_NODES]), .msgOp(linkOp[`RING_NODES]),
		.msgSeq(linkSeq[`RING_NODES]), .msgAddr(linkAddr[`RING_NODES]),
		.msgData(linkData[`RING_NODES]),
		.rspValid(rspValid), .rspOp(rspOp), .rspSeq(rspSeq), .rspData(rspData)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the ring testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ringTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VringTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF "All tests passed!"; then
	exit 0
fi
exit 1
